//--- multiCycleCpuWithMem.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/wordMemory.sv
rtl/multiCycleControl.sv
rtl/mipsAlu.sv
rtl/regFile.sv
rtl/multiCycleCpuWithMem.sv
sim/multiCycleCpuWithMemTb.sv

//--- rtl/cpuPkg.sv
package cpuPkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] immediate;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jTypeT;

    // one instruction word seen through the three formats
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        jTypeT jType;
    } instrFieldsT;

    typedef enum logic [1:0] { mtrAluOut, mtrMdr, mtrPc } memToRegT;
    typedef enum logic [1:0] { dstRt, dstRd, dstRa } regDstT;
    typedef enum logic [1:0] { pcsAlu, pcsAluOut, pcsJump } pcSourceT;
    typedef enum logic [1:0] { srcBReg, srcBFour, srcBImm, srcBImmShift } aluSrcBT;
    typedef enum logic [1:0] { opAdd, opSub, opFunct, opOpcode } aluOpT;

    typedef enum logic [2:0] { aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui } aluFuncT;

    typedef enum logic [3:0] {
        sFetch,
        sDecode,
        sMemAddr,
        sMemRead,
        sMemWriteback,
        sMemWrite,
        sExecute,
        sRWriteback,
        sImmWriteback,
        sBranch,
        sJump,
        sJumpLink
    } stateT;

    // bit 0 writes PC on zero, bit 1 on nonzero
    typedef struct packed {
        logic [1:0] pcWriteCond;
        logic       pcWrite;
        logic       iorD;
        logic       memRead;
        logic       memWrite;
        logic       irWrite;
        logic       aluSrcA;
        logic       regWrite;
        memToRegT   memToReg;
        regDstT     regDst;
        pcSourceT   pcSource;
        aluSrcBT    aluSrcB;
        aluOpT      aluOp;
    } ctrlWordT;

endpackage

//--- rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define XLEN      32
`define MEM_WORDS 256
`define RESET_PC  32'h0000_0000
`define RA_INDEX  5'd31

// opcodes
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_JAL    6'h03
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDI   6'h08
`define OP_LUI    6'h0F
`define OP_LW     6'h23
`define OP_SW     6'h2B

// R-type funct codes
`define FN_ADD    6'h20
`define FN_SUB    6'h22
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2A

`endif

//--- rtl/mipsAlu.sv
`include "cpu_consts.svh"

module mipsAlu (
    input  cpuPkg::aluOpT     aluOp,
    input  logic [5:0]        opcode,
    input  logic [5:0]        funct,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic [`XLEN-1:0]  result,
    output logic              zero
);
    cpuPkg::aluFuncT func;
    logic            lessThan;

    always_comb begin
        case (aluOp)
            cpuPkg::opAdd: func = cpuPkg::aluAdd;
            cpuPkg::opSub: func = cpuPkg::aluSub;
            cpuPkg::opFunct: begin
                case (funct)
                    `FN_SUB: func = cpuPkg::aluSub;
                    `FN_AND: func = cpuPkg::aluAnd;
                    `FN_OR:  func = cpuPkg::aluOr;
                    `FN_SLT: func = cpuPkg::aluSlt;
                    default: func = cpuPkg::aluAdd;
                endcase
            end
            // immediate forms, addi falls through to add
            default: func = (opcode == `OP_LUI) ? cpuPkg::aluLui : cpuPkg::aluAdd;
        endcase
    end

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (func)
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluSlt: result = {{(`XLEN-1){1'b0}}, lessThan};
            cpuPkg::aluLui: result = b << 16;
            default:        result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- rtl/multiCycleControl.sv
`include "cpu_consts.svh"

module multiCycleControl (
    input  logic              clk,
    input  logic              rstN,
    input  logic [5:0]        opcode,
    input  logic [5:0]        funct,
    output cpuPkg::ctrlWordT  ctrl
);
    cpuPkg::stateT state;
    cpuPkg::stateT nextState;
    logic          functOk;

    assign functOk = funct inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = cpuPkg::sFetch;
        case (state)
            cpuPkg::sFetch: nextState = cpuPkg::sDecode;
            cpuPkg::sDecode: begin
                case (opcode)
                    `OP_LW, `OP_SW: nextState = cpuPkg::sMemAddr;
                    `OP_ADDI, `OP_LUI: nextState = cpuPkg::sExecute;
                    `OP_BEQ, `OP_BNE: nextState = cpuPkg::sBranch;
                    `OP_J: nextState = cpuPkg::sJump;
                    `OP_JAL: nextState = cpuPkg::sJumpLink;
                    // unsupported funct behaves like an unknown opcode
                    `OP_RTYPE: nextState = functOk ? cpuPkg::sExecute : cpuPkg::sFetch;
                    default: nextState = cpuPkg::sFetch;
                endcase
            end
            cpuPkg::sMemAddr: begin
                nextState = (opcode == `OP_LW) ? cpuPkg::sMemRead : cpuPkg::sMemWrite;
            end
            cpuPkg::sMemRead: nextState = cpuPkg::sMemWriteback;
            cpuPkg::sExecute: begin
                if (opcode == `OP_RTYPE) begin
                    nextState = cpuPkg::sRWriteback;
                end else begin
                    nextState = cpuPkg::sImmWriteback;
                end
            end
            default: nextState = cpuPkg::sFetch;
        endcase
    end

    // Moore outputs, state plus opcode only
    always_comb begin
        ctrl = '0;
        case (state)
            cpuPkg::sFetch: begin
                ctrl.memRead  = 1'b1;
                ctrl.irWrite  = 1'b1;
                ctrl.aluSrcB  = cpuPkg::srcBFour;
                ctrl.aluOp    = cpuPkg::opAdd;
                ctrl.pcSource = cpuPkg::pcsAlu;
                ctrl.pcWrite  = 1'b1;
            end
            cpuPkg::sDecode: begin
                // branch target into ALUOut
                ctrl.aluSrcB = cpuPkg::srcBImmShift;
                ctrl.aluOp   = cpuPkg::opAdd;
            end
            cpuPkg::sMemAddr: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = cpuPkg::srcBImm;
                ctrl.aluOp   = cpuPkg::opAdd;
            end
            cpuPkg::sMemRead: begin
                ctrl.memRead = 1'b1;
                ctrl.iorD    = 1'b1;
            end
            cpuPkg::sMemWriteback: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = cpuPkg::dstRt;
                ctrl.memToReg = cpuPkg::mtrMdr;
            end
            cpuPkg::sMemWrite: begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = 1'b1;
            end
            cpuPkg::sExecute: begin
                ctrl.aluSrcA = 1'b1;
                if (opcode == `OP_RTYPE) begin
                    ctrl.aluSrcB = cpuPkg::srcBReg;
                    ctrl.aluOp   = cpuPkg::opFunct;
                end else begin
                    ctrl.aluSrcB = cpuPkg::srcBImm;
                    ctrl.aluOp   = cpuPkg::opOpcode;
                end
            end
            cpuPkg::sRWriteback: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = cpuPkg::dstRd;
                ctrl.memToReg = cpuPkg::mtrAluOut;
            end
            cpuPkg::sImmWriteback: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = cpuPkg::dstRt;
                ctrl.memToReg = cpuPkg::mtrAluOut;
            end
            cpuPkg::sBranch: begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = cpuPkg::srcBReg;
                ctrl.aluOp       = cpuPkg::opSub;
                ctrl.pcSource    = cpuPkg::pcsAluOut;
                ctrl.pcWriteCond = (opcode == `OP_BNE) ? 2'b10 : 2'b01;
            end
            cpuPkg::sJump: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = cpuPkg::pcsJump;
            end
            cpuPkg::sJumpLink: begin
                // PC already holds the return address here
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = cpuPkg::pcsJump;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = cpuPkg::dstRa;
                ctrl.memToReg = cpuPkg::mtrPc;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- rtl/multiCycleCpuWithMem.sv
`include "cpu_consts.svh"

module multiCycleCpuWithMem (
    input  logic              clk,
    input  logic              rstN,
    input  logic              loadEn,
    input  logic [`XLEN-1:0]  loadAddr,
    input  logic [`XLEN-1:0]  loadData,
    input  logic [4:0]        debugReg,
    output logic [`XLEN-1:0]  debugData,
    output logic [`XLEN-1:0]  instruction,
    output logic [`XLEN-1:0]  pcOut
);
    cpuPkg::ctrlWordT    ctrl;
    cpuPkg::instrFieldsT ir;

    // architectural registers
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] mdr;
    logic [`XLEN-1:0] regA;
    logic [`XLEN-1:0] regB;
    logic [`XLEN-1:0] aluOut;

    logic [`XLEN-1:0] memAddr;
    logic [`XLEN-1:0] memReadData;
    logic [`XLEN-1:0] rfReadData1;
    logic [`XLEN-1:0] rfReadData2;
    logic [`XLEN-1:0] rfWriteData;
    logic [4:0]       writeReg;
    logic [`XLEN-1:0] immExt;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic             aluZero;
    logic [`XLEN-1:0] jumpAddr;
    logic [`XLEN-1:0] nextPc;
    logic             pcEnable;

    assign pcEnable = ctrl.pcWrite
                    | (ctrl.pcWriteCond[0] & aluZero)
                    | (ctrl.pcWriteCond[1] & ~aluZero);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (pcEnable) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            ir <= memReadData;
        end
        mdr    <= memReadData;
        regA   <= rfReadData1;
        regB   <= rfReadData2;
        aluOut <= aluResult;
    end

    // lui takes the raw field, ALU does the shift
    assign immExt = (ir.iType.opcode == `OP_LUI)
                  ? {16'b0, ir.iType.immediate}
                  : {{16{ir.iType.immediate[15]}}, ir.iType.immediate};

    assign jumpAddr = {pc[`XLEN-1:`XLEN-4], ir.jType.target, 2'b00};
    assign memAddr  = ctrl.iorD ? aluOut : pc;
    assign srcA     = ctrl.aluSrcA ? regA : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            cpuPkg::srcBReg:  srcB = regB;
            cpuPkg::srcBFour: srcB = `XLEN'd4;
            cpuPkg::srcBImm:  srcB = immExt;
            default:          srcB = {immExt[`XLEN-3:0], 2'b00};
        endcase
    end

    always_comb begin
        case (ctrl.regDst)
            cpuPkg::dstRt: writeReg = ir.rType.rt;
            cpuPkg::dstRd: writeReg = ir.rType.rd;
            default:       writeReg = `RA_INDEX;
        endcase
    end

    always_comb begin
        case (ctrl.memToReg)
            cpuPkg::mtrAluOut: rfWriteData = aluOut;
            cpuPkg::mtrMdr:    rfWriteData = mdr;
            default:           rfWriteData = pc;
        endcase
    end

    always_comb begin
        case (ctrl.pcSource)
            cpuPkg::pcsAlu:    nextPc = aluResult;
            cpuPkg::pcsAluOut: nextPc = aluOut;
            default:           nextPc = jumpAddr;
        endcase
    end

    wordMemory memory_i (
        .clk         (clk),
        .addr        (memAddr),
        .writeEnable (ctrl.memWrite),
        .writeData   (regB),
        .readData    (memReadData),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData)
    );

    multiCycleControl control_i (
        .clk    (clk),
        .rstN   (rstN),
        .opcode (ir.rType.opcode),
        .funct  (ir.rType.funct),
        .ctrl   (ctrl)
    );

    mipsAlu alu_i (
        .aluOp  (ctrl.aluOp),
        .opcode (ir.rType.opcode),
        .funct  (ir.rType.funct),
        .a      (srcA),
        .b      (srcB),
        .result (aluResult),
        .zero   (aluZero)
    );

    regFile registers_i (
        .clk         (clk),
        .rstN        (rstN),
        .readReg1    (ir.rType.rs),
        .readReg2    (ir.rType.rt),
        .writeReg    (writeReg),
        .writeData   (rfWriteData),
        .writeEnable (ctrl.regWrite),
        .readData1   (rfReadData1),
        .readData2   (rfReadData2),
        .debugReg    (debugReg),
        .debugData   (debugData)
    );

    assign instruction = ir;
    assign pcOut       = pc;

endmodule

//--- rtl/regFile.sv
`include "cpu_consts.svh"

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  logic [4:0]        readReg1,
    input  logic [4:0]        readReg2,
    input  logic [4:0]        writeReg,
    input  logic [`XLEN-1:0]  writeData,
    input  logic              writeEnable,
    output logic [`XLEN-1:0]  readData1,
    output logic [`XLEN-1:0]  readData2,
    input  logic [4:0]        debugReg,
    output logic [`XLEN-1:0]  debugData
);
    logic [`XLEN-1:0] regs [32];

    // $zero is never written, so it reads back as zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeReg != 5'd0)) begin
            regs[writeReg] <= writeData;
        end
    end

    assign readData1 = regs[readReg1];
    assign readData2 = regs[readReg2];
    assign debugData = regs[debugReg];

endmodule

//--- rtl/wordMemory.sv
`include "cpu_consts.svh"

module wordMemory (
    input  logic              clk,
    input  logic [`XLEN-1:0]  addr,
    input  logic              writeEnable,
    input  logic [`XLEN-1:0]  writeData,
    output logic [`XLEN-1:0]  readData,
    input  logic              loadEn,
    input  logic [`XLEN-1:0]  loadAddr,
    input  logic [`XLEN-1:0]  loadData
);
    localparam int IdxBits = $clog2(`MEM_WORDS);

    logic [`XLEN-1:0]  mem [`MEM_WORDS];
    logic [IdxBits-1:0] cpuIdx;
    logic [IdxBits-1:0] loadIdx;

    // byte address to word index
    assign cpuIdx  = addr[IdxBits+1:2];
    assign loadIdx = loadAddr[IdxBits+1:2];

    // load port wins over the CPU port
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;
        end else if (writeEnable) begin
            mem[cpuIdx] <= writeData;
        end
    end

    assign readData = mem[cpuIdx];

endmodule

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f multiCycleCpuWithMem.f \
    --top-module multiCycleCpuWithMemTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- sim/cpuCases.txt
# keywords prog end regs run, all numbers hex
# prog: words from address 0 up, end: PC of the final self jump, regs: index value pairs
# add sub and or slt addi lui, writes to $zero dropped
prog 20080007 2009fffd 01095020 01095822 01096024 01096825
prog 0128702a 0109782a 3c101234 22105678 01080020 20000005 0800000c
end 30
regs 0 00000000 8 00000007 9 fffffffd a 00000004 b 0000000a
regs c 00000005 d ffffffff e 00000001 f 00000000 10 12345678
run
# sw then lw into other registers, positive and negative offsets
prog 20080100 3c09cafe 21291234 ad090008 8d0a0008 ad08fffc 8c0b00fc 08000007
end 1c
regs 8 00000100 9 cafe1234 a cafe1234 b 00000100
run
# beq and bne, taken and not taken
prog 20080005 20090005 11090001 200a0001 15090001 200b0002
prog 110b0001 200c0003 150b0001 200d0004 0800000a
end 28
regs 8 00000005 9 00000005 a 00000000 b 00000002 c 00000003 d 00000000
run
# jal, j, link copied out before the second jal
prog 0c000004 20080001 20090001 200a0001 23eb0000 08000008
prog 200c0001 200d0001 0c00000a 200e0001 0800000a
end 28
regs 8 00000000 9 00000000 a 00000000 b 00000004 c 00000000
regs d 00000000 e 00000000 1f 00000024
run
# countdown loop with bne, sum of 5..1
prog 20080005 20090000 01284820 2108ffff 1500fffd 08000005
end 14
regs 8 00000000 9 0000000f
run

//--- sim/multiCycleCpuWithMemTb.sv
`include "cpu_consts.svh"

module multiCycleCpuWithMemTb;

    logic             clk;
    logic             rstN;
    logic             loadEn;
    logic [`XLEN-1:0] loadAddr;
    logic [`XLEN-1:0] loadData;
    logic [4:0]       debugReg;
    logic [`XLEN-1:0] debugData;
    logic [`XLEN-1:0] instruction;
    logic [`XLEN-1:0] pcOut;

    int cycleCount;
    int cycleLimit;

    // current case as filled by the file parser
    logic [`XLEN-1:0] programWords[$];
    logic [`XLEN-1:0] endPc;
    logic [4:0]       expIdx[$];
    logic [`XLEN-1:0] expVal[$];

    multiCycleCpuWithMem dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .debugReg    (debugReg),
        .debugData   (debugData),
        .instruction (instruction),
        .pcOut       (pcOut)
    );

    always #50 clk = ~clk;

    // run budget grows by 5 cycles per word plus 200 per case
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no end PC reached within %0d cycles", cycleLimit);
            $display("Something failed");
            $fatal(1);
        end
    end

    // words go in one per clock while the CPU sits in reset
    task automatic loadProgram();
        @(negedge clk);
        rstN = 1'b0;
        foreach (programWords[i]) begin
            loadEn   = 1'b1;
            loadAddr = i * 4;
            loadData = programWords[i];
            @(negedge clk);
        end
        loadEn = 1'b0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
    endtask

    // done once the self jump at endPc has been fetched and taken
    task automatic runToEnd();
        logic [`XLEN-1:0] selfJump;
        selfJump = {`OP_J, endPc[27:2]};
        while (!((pcOut === endPc) && (instruction === selfJump))) begin
            @(negedge clk);
        end
    endtask

    task automatic checkRegister(input logic [4:0] idx, input logic [`XLEN-1:0] expected);
        logic [`XLEN-1:0] got;
        @(negedge clk);
        debugReg = idx;
        @(negedge clk);
        got = debugData;
        assert (got === expected) else begin
            $display("MISMATCH debugData reg %0d expected %h got %h", idx, expected, got);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic runCase();
        cycleLimit += 5 * programWords.size() + 200;
        loadProgram();
        runToEnd();
        foreach (expIdx[k]) begin
            checkRegister(expIdx[k], expVal[k]);
        end
    endtask

    initial begin
        int               fd;
        int               caseCount;
        string            tok;
        string            line;
        string            mode;
        logic [`XLEN-1:0] value;
        logic [4:0]       pendingIdx;
        bit               haveIdx;

        clk        = 1'b0;
        rstN       = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        debugReg   = '0;
        cycleCount = 0;
        cycleLimit = 0;
        caseCount  = 0;
        mode       = "";
        haveIdx    = 1'b0;
        pendingIdx = '0;

        fd = $fopen("sim/cpuCases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/cpuCases.txt");
            $display("Something failed");
            $fatal(1);
        end

        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                void'($fgets(line, fd));
            end else if (tok == "prog" || tok == "end" || tok == "regs") begin
                mode    = tok;
                haveIdx = 1'b0;
            end else if (tok == "run") begin
                runCase();
                caseCount++;
                programWords.delete();
                expIdx.delete();
                expVal.delete();
                mode = "";
            end else begin
                void'($sscanf(tok, "%h", value));
                if (mode == "prog") begin
                    programWords.push_back(value);
                end else if (mode == "end") begin
                    endPc = value;
                end else if (mode == "regs" && !haveIdx) begin
                    pendingIdx = value[4:0];
                    haveIdx    = 1'b1;
                end else if (mode == "regs") begin
                    expIdx.push_back(pendingIdx);
                    expVal.push_back(value);
                    haveIdx = 1'b0;
                end
            end
        end
        $fclose(fd);

        if (caseCount == 0) begin
            $display("no test cases found in sim/cpuCases.txt");
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
